/* design/cart_pkg.sv */
package cart_pkg;

  //////////////////////////////
  // Widths with a meaning
  //////////////////////////////

  // Console side address as seen on the SNES bus
  typedef logic [23:0] snes_addr_t;

  // Linear address inside the cartridge memory
  typedef logic [23:0] phys_addr_t;

  // Data bus
  typedef logic [7:0]  byte_t;

  // Feature enables from the MCU
  typedef logic [7:0]  feat_t;

  //////////////////////////////
  // Constants
  //////////////////////////////

  // Feature bit positions
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;

  // Save RAM lives at the top of the physical space
  localparam phys_addr_t SAVE_BASE = 24'hE00000;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  // One console bus cycle
  typedef struct packed {
    snes_addr_t addr;
    byte_t      pa;     // B bus address
    byte_t      wdata;
    logic       we;
  } snes_req_t;

  // One SRAM access
  typedef struct packed {
    phys_addr_t addr;
    byte_t      wdata;
    logic       we;
  } mem_req_t;

  // Decoder result for memory space
  typedef struct packed {
    logic       is_rom;
    logic       is_saveram;
    logic       writable;
    logic       rom_hit;
    phys_addr_t phys;
  } cart_map_t;

  // Qualified selects for the external peripherals
  typedef struct packed {
    logic msu;
    logic r213f;
    logic gsu;
    logic snescmd;
  } periph_sel_t;

endpackage

/* design/cart_address.sv */
`timescale 1ns/1ps

module cart_address (
  input  cart_pkg::snes_req_t   req,
  input  cart_pkg::feat_t       feat,
  input  cart_pkg::phys_addr_t  rom_mask,
  input  cart_pkg::phys_addr_t  save_mask,
  output cart_pkg::cart_map_t   map,
  output cart_pkg::periph_sel_t sel
);

  cart_pkg::snes_addr_t a;
  cart_pkg::phys_addr_t save_off;
  cart_pkg::phys_addr_t rom_off;
  logic                 save_en;
  logic                 is_rom;
  logic                 is_saveram;

  assign a       = req.addr;
  // Save RAM switched off by a clear mask bit 0
  assign save_en = save_mask[0];

  //////////////////////////////
  // Region hits
  //////////////////////////////

  // Upper half banks or upper 32K of any bank
  assign is_rom = a[22] | a[15];

  // Banks 70-7F/F0-FF, or 6000-7FFF in the low banks
  assign is_saveram = save_en
                    & ((&a[22:20])
                      | (~a[22] & ~a[15] & (&a[14:13])));

  assign map.is_rom     = is_rom;
  assign map.is_saveram = is_saveram;
  assign map.writable   = is_saveram;
  assign map.rom_hit    = is_rom | is_saveram;

  //////////////////////////////
  // Physical address
  //////////////////////////////

  // Full bank offset in the upper half, 8K window below
  assign save_off = a[22] ? {4'h0, a[19:0]} : {11'h000, a[12:0]};

  // HiROM style above bank 40, LoROM style below
  assign rom_off = a[22] ? {2'b00, a[21:0]} : {2'b00, a[22:16], a[14:0]};

  assign map.phys = is_saveram ? cart_pkg::SAVE_BASE + (save_off & save_mask)
                               : rom_off & rom_mask;

  //////////////////////////////
  // Peripheral windows
  //////////////////////////////

  // MSU1 registers at 2000-2007
  assign sel.msu = feat[cart_pkg::FEAT_MSU1] & ~a[22]
                 & ((a[15:0] & 16'hFFF8) == 16'h2000);

  // PPU status readback on B bus 3F
  assign sel.r213f = feat[cart_pkg::FEAT_213F] & (req.pa == 8'h3F);

  // GSU registers 3000-32FF, top quarter excluded
  assign sel.gsu = ~a[22] & (a[15:10] == 6'b001100) & (a[9:8] != 2'b11);

  // Command buffer 2A00-2BFF
  assign sel.snescmd = ~a[22] & (a[15:9] == 7'b0010101);

endmodule

/* design/snes_bus_port.sv */
`timescale 1ns/1ps

module snes_bus_port (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  cart_pkg::snes_req_t   req,
  output logic                  rsp_valid,
  output cart_pkg::byte_t       rsp_rdata,
  input  cart_pkg::feat_t       feat,
  input  cart_pkg::phys_addr_t  rom_mask,
  input  cart_pkg::phys_addr_t  save_mask,
  output cart_pkg::periph_sel_t periph_sel,
  output logic                  mem_valid,
  output cart_pkg::mem_req_t    mem_req,
  input  logic                  grant,
  input  logic                  mem_rsp_valid,
  input  cart_pkg::byte_t       mem_rdata
);

  typedef enum logic [1:0] {
    st_idle,
    st_local,
    st_mem_wait,
    st_mem_rsp
  } state_t;

  state_t                state;
  state_t                state_nxt;
  cart_pkg::snes_req_t   req_q;
  cart_pkg::snes_req_t   req_cur;
  cart_pkg::cart_map_t   map;
  cart_pkg::periph_sel_t sel;
  logic                  accept;
  logic                  mem_acc;

  assign accept = req_valid & req_ready;

  // Live request while idle, held copy once accepted
  assign req_cur = (state == st_idle) ? req : req_q;

  cart_address u_cart_address (
    .req       (req_cur),
    .feat      (feat),
    .rom_mask  (rom_mask),
    .save_mask (save_mask),
    .map       (map),
    .sel       (sel)
  );

  // Reads hit ROM or save RAM, writes only save RAM
  assign mem_acc = req_cur.we ? map.writable : map.rom_hit;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
  end

  //////////////////////////////
  // Access FSM
  //////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      // Dropped writes and peripheral space end up local
      st_idle:     if (accept) state_nxt = mem_acc ? st_mem_wait : st_local;
      st_local:    state_nxt = st_idle;
      st_mem_wait: if (grant) state_nxt = st_mem_rsp;
      st_mem_rsp:  if (mem_rsp_valid) state_nxt = st_idle;
      default:     state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      req_ready <= 1'b0;
    end else begin
      state     <= state_nxt;
      req_ready <= (state_nxt == st_idle);
    end
  end

  // Memory request stays up until the arbiter takes it
  assign mem_valid = (state == st_mem_wait);
  assign mem_req   = '{addr: map.phys, wdata: req_cur.wdata, we: req_cur.we};

  assign rsp_valid = (state == st_local) | ((state == st_mem_rsp) & mem_rsp_valid);
  // Open bus value unless a memory read
  assign rsp_rdata = ((state == st_mem_rsp) && !req_q.we) ? mem_rdata : 8'hFF;

  assign periph_sel = (state == st_idle) ? '0 : sel;

  // Request held steady under back pressure
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_valid && !grant |=> $stable(mem_req));

endmodule

/* design/mcu_loader_port.sv */
`timescale 1ns/1ps

module mcu_loader_port (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  output logic               req_ready,
  input  cart_pkg::mem_req_t req,
  output logic               rsp_valid,
  output cart_pkg::byte_t    rsp_rdata,
  output logic               mem_valid,
  output cart_pkg::mem_req_t mem_req,
  input  logic               grant,
  input  logic               mem_rsp_valid,
  input  cart_pkg::byte_t    mem_rdata
);

  cart_pkg::mem_req_t req_q;
  logic               pending;
  logic               waiting;
  logic               pending_nxt;
  logic               waiting_nxt;
  logic               accept;

  assign accept = req_valid & req_ready;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
  end

  // Pending until granted, then waiting for the SRAM data
  assign pending_nxt = accept | (pending & ~grant);
  assign waiting_nxt = (pending & grant) | (waiting & ~mem_rsp_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      pending   <= 1'b0;
      waiting   <= 1'b0;
      req_ready <= 1'b0;
    end else begin
      pending   <= pending_nxt;
      waiting   <= waiting_nxt;
      req_ready <= ~(pending_nxt | waiting_nxt);
    end
  end

  assign mem_valid = pending;
  assign mem_req   = req_q;

  assign rsp_valid = waiting & mem_rsp_valid;
  // Writes answer with FF
  assign rsp_rdata = req_q.we ? 8'hFF : mem_rdata;

  // One access in flight until its response
  a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    accept |=> (!accept until_with rsp_valid));

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  logic               snes_valid,
  input  cart_pkg::mem_req_t snes_req,
  output logic               snes_grant,
  output logic               snes_rsp_valid,
  input  logic               mcu_valid,
  input  cart_pkg::mem_req_t mcu_req,
  output logic               mcu_grant,
  output logic               mcu_rsp_valid,
  output cart_pkg::byte_t    rsp_rdata,
  output logic               mem_en,
  output cart_pkg::mem_req_t mem_req,
  input  cart_pkg::byte_t    mem_rdata
);

  // High when the MCU wins a tie
  logic prio_mcu;
  // Owner of the access now in the SRAM
  logic owner_snes;
  logic rsp_pend;

  //////////////////////////////
  // Grant
  //////////////////////////////

  assign snes_grant = snes_valid & (~mcu_valid | ~prio_mcu);
  assign mcu_grant  = mcu_valid & (~snes_valid | prio_mcu);

  assign mem_en  = snes_grant | mcu_grant;
  assign mem_req = snes_grant ? snes_req : mcu_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      prio_mcu   <= 1'b1;
      owner_snes <= 1'b0;
      rsp_pend   <= 1'b0;
    end else begin
      // Winner goes to the back
      if (mem_en) begin
        prio_mcu <= snes_grant;
      end
      owner_snes <= snes_grant;
      rsp_pend   <= mem_en;
    end
  end

  //////////////////////////////
  // Response steering
  //////////////////////////////

  // SRAM data lands one cycle after the grant
  assign snes_rsp_valid = rsp_pend & owner_snes;
  assign mcu_rsp_valid  = rsp_pend & ~owner_snes;
  assign rsp_rdata      = mem_rdata;

  // Back to back ties go to the other peer
  a_grant_alternate: assert property (@(posedge clk) disable iff (rst)
    snes_valid && mcu_valid |=> !(snes_valid && mcu_valid)
                                || (snes_grant != $past(snes_grant)));

endmodule

/* design/cart_sram.sv */
`timescale 1ns/1ps

module cart_sram #(
  parameter int MEM_AW = 16
) (
  input  logic               clk,
  input  logic               en,
  input  cart_pkg::mem_req_t req,
  output cart_pkg::byte_t    rdata
);

  cart_pkg::byte_t   mem [2**MEM_AW];
  logic [MEM_AW-1:0] idx;

  //////////////////////////////
  // Index
  //////////////////////////////

  // Bit 23 picks ROM half or save half
  assign idx = {req.addr[23], req.addr[MEM_AW-2:0]};

  // Write or registered read, one port
  always_ff @(posedge clk) begin
    if (en) begin
      if (req.we) begin
        mem[idx] <= req.wdata;
      end else begin
        rdata <= mem[idx];
      end
    end
  end

endmodule

/* design/cart_top.sv */
`timescale 1ns/1ps

module cart_top #(
  parameter int MEM_AW = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  cart_pkg::feat_t       feat,
  input  cart_pkg::phys_addr_t  rom_mask,
  input  cart_pkg::phys_addr_t  save_mask,
  input  logic                  snes_req_valid,
  output logic                  snes_req_ready,
  input  cart_pkg::snes_req_t   snes_req,
  output logic                  snes_rsp_valid,
  output cart_pkg::byte_t       snes_rsp_rdata,
  output cart_pkg::periph_sel_t periph_sel,
  input  logic                  mcu_req_valid,
  output logic                  mcu_req_ready,
  input  cart_pkg::mem_req_t    mcu_req,
  output logic                  mcu_rsp_valid,
  output cart_pkg::byte_t       mcu_rsp_rdata
);

  // Console peer to arbiter
  logic               snes_mem_valid;
  cart_pkg::mem_req_t snes_mem_req;
  logic               snes_grant;
  logic               snes_mem_rsp_valid;

  // MCU peer to arbiter
  logic               mcu_mem_valid;
  cart_pkg::mem_req_t mcu_mem_req;
  logic               mcu_grant;
  logic               mcu_mem_rsp_valid;

  // Arbiter to SRAM
  cart_pkg::byte_t    arb_rdata;
  logic               mem_en;
  cart_pkg::mem_req_t mem_req;
  cart_pkg::byte_t    mem_rdata;

  snes_bus_port u_snes_bus_port (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (snes_req_valid),
    .req_ready     (snes_req_ready),
    .req           (snes_req),
    .rsp_valid     (snes_rsp_valid),
    .rsp_rdata     (snes_rsp_rdata),
    .feat          (feat),
    .rom_mask      (rom_mask),
    .save_mask     (save_mask),
    .periph_sel    (periph_sel),
    .mem_valid     (snes_mem_valid),
    .mem_req       (snes_mem_req),
    .grant         (snes_grant),
    .mem_rsp_valid (snes_mem_rsp_valid),
    .mem_rdata     (arb_rdata)
  );

  mcu_loader_port u_mcu_loader_port (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (mcu_req_valid),
    .req_ready     (mcu_req_ready),
    .req           (mcu_req),
    .rsp_valid     (mcu_rsp_valid),
    .rsp_rdata     (mcu_rsp_rdata),
    .mem_valid     (mcu_mem_valid),
    .mem_req       (mcu_mem_req),
    .grant         (mcu_grant),
    .mem_rsp_valid (mcu_mem_rsp_valid),
    .mem_rdata     (arb_rdata)
  );

  mem_arbiter u_mem_arbiter (
    .clk            (clk),
    .rst            (rst),
    .snes_valid     (snes_mem_valid),
    .snes_req       (snes_mem_req),
    .snes_grant     (snes_grant),
    .snes_rsp_valid (snes_mem_rsp_valid),
    .mcu_valid      (mcu_mem_valid),
    .mcu_req        (mcu_mem_req),
    .mcu_grant      (mcu_grant),
    .mcu_rsp_valid  (mcu_mem_rsp_valid),
    .rsp_rdata      (arb_rdata),
    .mem_en         (mem_en),
    .mem_req        (mem_req),
    .mem_rdata      (mem_rdata)
  );

  cart_sram #(
    .MEM_AW (MEM_AW)
  ) u_cart_sram (
    .clk   (clk),
    .en    (mem_en),
    .req   (mem_req),
    .rdata (mem_rdata)
  );

endmodule

/* tb/tb_cart_top.sv */
`timescale 1ns/1ps

module tb_cart_top;

  localparam int MEM_AW     = 16;
  localparam int WAIT_LIMIT = 60;
  localparam int ROM_COUNT  = 32;

  logic                  clk;
  logic                  rst;
  cart_pkg::feat_t       feat;
  cart_pkg::phys_addr_t  rom_mask;
  cart_pkg::phys_addr_t  save_mask;
  logic                  snes_req_valid;
  logic                  snes_req_ready;
  cart_pkg::snes_req_t   snes_req;
  logic                  snes_rsp_valid;
  cart_pkg::byte_t       snes_rsp_rdata;
  cart_pkg::periph_sel_t periph_sel;
  logic                  mcu_req_valid;
  logic                  mcu_req_ready;
  cart_pkg::mem_req_t    mcu_req;
  logic                  mcu_rsp_valid;
  cart_pkg::byte_t       mcu_rsp_rdata;

  // Expected response of the access in flight, one per port
  cart_pkg::byte_t       exp_snes_rdata;
  cart_pkg::periph_sel_t exp_sel;
  logic                  exp_local;
  cart_pkg::byte_t       exp_mcu_rdata;

  // Reference SRAM image and the ROM addresses loaded in test 1
  cart_pkg::byte_t       ref_mem [2**MEM_AW];
  cart_pkg::phys_addr_t  rom_list [ROM_COUNT];
  logic [31:0]           rng_state;

  cart_top #(
    .MEM_AW (MEM_AW)
  ) u_dut (
    .clk            (clk),
    .rst            (rst),
    .feat           (feat),
    .rom_mask       (rom_mask),
    .save_mask      (save_mask),
    .snes_req_valid (snes_req_valid),
    .snes_req_ready (snes_req_ready),
    .snes_req       (snes_req),
    .snes_rsp_valid (snes_rsp_valid),
    .snes_rsp_rdata (snes_rsp_rdata),
    .periph_sel     (periph_sel),
    .mcu_req_valid  (mcu_req_valid),
    .mcu_req_ready  (mcu_req_ready),
    .mcu_req        (mcu_req),
    .mcu_rsp_valid  (mcu_rsp_valid),
    .mcu_rsp_rdata  (mcu_rsp_rdata)
  );

  // 40 ns period
  always #20 clk = ~clk;

  //////////////////////////////
  // Failure reporting
  //////////////////////////////

  task automatic check_failed(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("ERR %s got %h expected %h", name, got, exp);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic map_rom(input cart_pkg::snes_addr_t a);
    return a[22] || a[15];
  endfunction

  function automatic logic map_save(input cart_pkg::snes_addr_t a);
    logic hi_win;
    logic lo_win;
    hi_win = a[22] && a[21] && a[20];
    lo_win = !a[22] && !a[15] && a[14] && a[13];
    return save_mask[0] && (hi_win || lo_win);
  endfunction

  function automatic cart_pkg::phys_addr_t map_phys(input cart_pkg::snes_addr_t a);
    cart_pkg::phys_addr_t off;
    if (map_save(a)) begin
      if (a[22]) off = 24'(a[19:0]);
      else off = 24'(a[12:0]);
      return cart_pkg::SAVE_BASE + (off & save_mask);
    end
    // HiROM above bank 40, LoROM drops bit 15
    if (a[22]) return 24'(a[21:0]) & rom_mask;
    return {2'b00, a[22:16], a[14:0]} & rom_mask;
  endfunction

  function automatic cart_pkg::periph_sel_t decode_sel(input cart_pkg::snes_addr_t a,
                                                       input cart_pkg::byte_t pa);
    cart_pkg::periph_sel_t s;
    logic [15:0]           lo;
    lo        = a[15:0];
    s.msu     = feat[cart_pkg::FEAT_MSU1] && !a[22] && lo >= 16'h2000 && lo <= 16'h2007;
    s.r213f   = feat[cart_pkg::FEAT_213F] && pa == 8'h3F;
    s.gsu     = !a[22] && lo >= 16'h3000 && lo <= 16'h32FF;
    s.snescmd = !a[22] && lo >= 16'h2A00 && lo <= 16'h2BFF;
    return s;
  endfunction

  // Bit 23 then the low physical bits
  function automatic logic [MEM_AW-1:0] sram_index(input cart_pkg::phys_addr_t p);
    return {p[23], p[MEM_AW-2:0]};
  endfunction

  // Console address that maps onto a ROM physical address
  function automatic cart_pkg::snes_addr_t console_view(input cart_pkg::phys_addr_t p,
                                                        input logic hirom,
                                                        input logic [31:0] r);
    if (hirom) return {3'b110, r[4:0], 1'b0, p[14:0]};
    return {2'b00, r[5:0], 1'b1, p[14:0]};
  endfunction

  //////////////////////////////
  // Bus drivers
  //////////////////////////////

  task automatic snes_access(input cart_pkg::snes_addr_t addr, input cart_pkg::byte_t pa,
                             input cart_pkg::byte_t wdata, input logic we);
    cart_pkg::phys_addr_t phys;
    cart_pkg::byte_t      exp;
    logic                 mem_op;
    int                   cnt;
    @(posedge clk);
    phys = map_phys(addr);
    if (we) begin
      mem_op = map_save(addr);
      exp    = 8'hFF;
      if (mem_op) ref_mem[sram_index(phys)] = wdata;
    end else begin
      mem_op = map_rom(addr) || map_save(addr);
      exp    = mem_op ? ref_mem[sram_index(phys)] : 8'hFF;
    end
    snes_req_valid <= 1'b1;
    snes_req       <= '{addr: addr, pa: pa, wdata: wdata, we: we};
    exp_snes_rdata <= exp;
    exp_sel        <= decode_sel(addr, pa);
    exp_local      <= !mem_op;
    cnt = 0;
    @(negedge clk);
    while (!snes_req_ready) begin
      cnt++;
      if (cnt > WAIT_LIMIT) check_failed("console request was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    snes_req_valid <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!snes_rsp_valid) begin
      cnt++;
      if (cnt > WAIT_LIMIT) check_failed("console response never arrived");
      @(negedge clk);
    end
  endtask

  task automatic mcu_access(input cart_pkg::phys_addr_t addr, input cart_pkg::byte_t wdata,
                            input logic we);
    int cnt;
    @(posedge clk);
    if (we) ref_mem[sram_index(addr)] = wdata;
    mcu_req_valid <= 1'b1;
    mcu_req       <= '{addr: addr, wdata: wdata, we: we};
    exp_mcu_rdata <= we ? 8'hFF : ref_mem[sram_index(addr)];
    cnt = 0;
    @(negedge clk);
    while (!mcu_req_ready) begin
      cnt++;
      if (cnt > WAIT_LIMIT) check_failed("MCU request was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    mcu_req_valid <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!mcu_rsp_valid) begin
      cnt++;
      if (cnt > WAIT_LIMIT) check_failed("MCU response never arrived");
      @(negedge clk);
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_snes_data: assert property (@(posedge clk) disable iff (rst)
    snes_rsp_valid |-> snes_rsp_rdata == exp_snes_rdata)
    else value_mismatch("snes_rsp_rdata", $sampled(snes_rsp_rdata), $sampled(exp_snes_rdata));

  a_mcu_data: assert property (@(posedge clk) disable iff (rst)
    mcu_rsp_valid |-> mcu_rsp_rdata == exp_mcu_rdata)
    else value_mismatch("mcu_rsp_rdata", $sampled(mcu_rsp_rdata), $sampled(exp_mcu_rdata));

  a_periph_sel: assert property (@(posedge clk) disable iff (rst)
    snes_rsp_valid |-> periph_sel == exp_sel)
    else value_mismatch("periph_sel", $sampled(periph_sel), $sampled(exp_sel));

  // Local answer exactly one cycle after acceptance
  a_local_timing: assert property (@(posedge clk) disable iff (rst)
    snes_req_valid && snes_req_ready && exp_local |=> snes_rsp_valid)
    else check_failed("local console access was not answered one cycle after acceptance");

  // Memory path takes two cycles or more
  a_mem_latency: assert property (@(posedge clk) disable iff (rst)
    snes_req_valid && snes_req_ready && !exp_local |=> !snes_rsp_valid)
    else check_failed("console memory access answered after a single cycle");

  a_snes_fair: assert property (@(posedge clk) disable iff (rst)
    u_dut.snes_mem_valid |-> ##[0:2] u_dut.snes_grant)
    else check_failed("console port waited too long for a grant");

  a_mcu_fair: assert property (@(posedge clk) disable iff (rst)
    u_dut.mcu_mem_valid |-> ##[0:2] u_dut.mcu_grant)
    else check_failed("MCU port waited too long for a grant");

  a_reset_outputs: assert property (@(posedge clk)
    rst |=> !snes_req_ready && !snes_rsp_valid && !mcu_req_ready && !mcu_rsp_valid
            && !u_dut.mem_en && periph_sel == '0)
    else check_failed("outputs not cleared by reset");

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    cart_pkg::byte_t    save_a;
    cart_pkg::byte_t    save_b;
    cart_pkg::snes_addr_t a;
    int                 con_pick [16];
    int                 mcu_pick [16];
    logic               con_hi [16];
    logic [31:0]        con_bank [16];
    rng_state      = 32'h5fd1;
    clk            = 1'b0;
    rst            = 1'b1;
    feat           = 8'h18;
    rom_mask       = 24'h007FFF;
    save_mask      = 24'h001FFF;
    snes_req_valid = 1'b0;
    snes_req       = '0;
    mcu_req_valid  = 1'b0;
    mcu_req        = '0;
    exp_snes_rdata = 8'hFF;
    exp_sel        = '0;
    exp_local      = 1'b0;
    exp_mcu_rdata  = 8'hFF;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // Test 1 ROM load by the MCU, LoROM and HiROM reads
    for (int i = 0; i < ROM_COUNT; i++) begin
      rom_list[i] = 24'(lcg_next() >> 4) & 24'h007FFF;
      mcu_access(rom_list[i], cart_pkg::byte_t'(lcg_next() >> 8), 1'b1);
    end
    for (int i = 0; i < ROM_COUNT; i++) begin
      snes_access(console_view(rom_list[i], 1'b0, lcg_next()), 8'h00, 8'h00, 1'b0);
      snes_access(console_view(rom_list[i], 1'b1, lcg_next()), 8'h00, 8'h00, 1'b0);
    end

    // Test 2 save RAM written by the console, read by the MCU
    save_a = cart_pkg::byte_t'(lcg_next() >> 8);
    save_b = cart_pkg::byte_t'(lcg_next() >> 8);
    snes_access(24'h700123, 8'h00, save_a, 1'b1);
    snes_access(24'h006456, 8'h00, save_b, 1'b1);
    mcu_access(cart_pkg::SAVE_BASE + 24'h000123, 8'h00, 1'b0);
    mcu_access(cart_pkg::SAVE_BASE + 24'h000456, 8'h00, 1'b0);
    // Mirrors above the save mask
    snes_access(24'h702123, 8'h00, 8'h00, 1'b0);
    snes_access(24'h70A123, 8'h00, 8'h00, 1'b0);

    // Test 3 ROM write dropped, MSU1 window answered locally
    a = console_view(rom_list[0], 1'b0, 32'h0);
    snes_access(a, 8'h00, ~ref_mem[sram_index(rom_list[0])], 1'b1);
    snes_access(a, 8'h00, 8'h00, 1'b0);
    snes_access(24'h002003, 8'h00, 8'h00, 1'b0);

    // Test 4 peripheral selects
    snes_access(24'h003100, 8'h00, 8'h00, 1'b0);
    snes_access(24'h002A10, 8'h00, 8'h00, 1'b0);
    snes_access(24'h002100, 8'h3F, 8'h00, 1'b0);
    snes_access(24'h003300, 8'h00, 8'h00, 1'b0);

    // Test 5 both peers in the same cycles, disjoint ROM halves
    for (int k = 0; k < 16; k++) begin
      con_pick[k] = int'(lcg_next() >> 12) % 16;
      mcu_pick[k] = 16 + int'(lcg_next() >> 12) % 16;
      con_hi[k]   = lcg_next() >> 31;
      con_bank[k] = lcg_next();
    end
    fork
      begin
        for (int k = 0; k < 16; k++) begin
          a = console_view(rom_list[con_pick[k]], con_hi[k], con_bank[k]);
          snes_access(a, 8'h00, 8'h00, 1'b0);
        end
      end
      begin
        for (int k = 0; k < 16; k++) begin
          mcu_access(rom_list[mcu_pick[k]], 8'h00, 1'b0);
        end
      end
    join

    // Test 6 features off, then save RAM off
    @(posedge clk);
    feat <= 8'h00;
    snes_access(24'h002003, 8'h00, 8'h00, 1'b0);
    snes_access(24'h002100, 8'h3F, 8'h00, 1'b0);
    @(posedge clk);
    save_mask <= 24'h001FFE;
    snes_access(24'h700123, 8'h00, ~save_a, 1'b1);
    @(posedge clk);
    save_mask <= 24'h001FFF;
    // Old byte still in place
    mcu_access(cart_pkg::SAVE_BASE + 24'h000123, 8'h00, 1'b0);

    repeat (2) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* verilog.f */
design/cart_pkg.sv
design/cart_address.sv
design/snes_bus_port.sv
design/mcu_loader_port.sv
design/mem_arbiter.sv
design/cart_sram.sv
design/cart_top.sv
tb/tb_cart_top.sv

/* Bender.yml */
package:
  name: cart_mem_path

sources:
  # Package first, then the RTL in dependency order
  - design/cart_pkg.sv
  - design/cart_address.sv
  - design/snes_bus_port.sv
  - design/mcu_loader_port.sv
  - design/mem_arbiter.sv
  - design/cart_sram.sv
  - design/cart_top.sv

  # Testbench
  - target: test
    files:
      - tb/tb_cart_top.sv
